// File: hdl/ingress_pkg.sv
//////////////////////////////////////////////////
// Router ingress port mix, buffer sizes and the
// data types shared by the ingress stage
//////////////////////////////////////////////////

package ingress_pkg;

    //////////////////////////////////////////////////
    // Port mix and sizes

    // 8-bit ports take indices 0 and 1, 32-bit ports 2 and 3
    localparam int NUM_8B_PORTS  = 2;
    localparam int NUM_32B_PORTS = 2;
    localparam int NUM_PORTS     = NUM_8B_PORTS + NUM_32B_PORTS;

    // Bytes per word on the merged stream
    localparam int OUT_BYTES  = 8;

    // Room for two 64-byte packets per port
    localparam int FIFO_DEPTH = 16;
    localparam int CNT_W      = 16;

    //////////////////////////////////////////////////
    // Types

    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;
    typedef logic [OUT_BYTES*8-1:0]       out_data_t;
    typedef logic [OUT_BYTES-1:0]         out_keep_t;
    typedef logic [7:0]                   word8_t;
    typedef logic [31:0]                  word32_t;

    // One buffered 64-bit word, bytes packed from lane 0 upwards
    typedef struct packed {
        out_data_t data;
        out_keep_t keep;
        logic      last;
    } fifo_entry_t;

    // Extra top bit tells a full FIFO from an empty one
    typedef logic [$clog2(FIFO_DEPTH):0] fifo_ptr_t;
    typedef logic [CNT_W-1:0]            cnt_t;

endpackage

// File: hdl/port_widener.sv
//////////////////////////////////////////////////
// Packs narrow port words into 64-bit FIFO entries
//////////////////////////////////////////////////
`timescale 1ns/1ps

module port_widener import ingress_pkg::*; #(
    parameter type in_word_t = word8_t
) (
    input  logic        clk_ifc,
    input  logic        arst_n,
    input  logic        port_valid,
    input  in_word_t    port_data,
    input  logic        port_last,
    input  logic        port_enable,
    output logic        wr_valid,
    output fifo_entry_t wr_entry,
    output logic        pkt_end
);

    localparam int IN_BYTES = $bits(in_word_t) / 8;
    localparam int FILL_W   = $clog2(OUT_BYTES) + 1;

    logic [FILL_W-1:0] fill;
    logic [FILL_W-1:0] fill_next;
    out_data_t         asm_data;
    out_data_t         asm_next;
    out_keep_t         keep_next;
    logic              pkt_open;
    logic              drop_pkt;
    logic              word_drop;
    logic              take;
    logic              complete;

    // Enable only matters on the first word of a packet
    assign word_drop = pkt_open ? drop_pkt : !port_enable;
    assign take      = port_valid && !word_drop;
    assign fill_next = fill + FILL_W'(IN_BYTES);
    assign complete  = port_last || (fill_next == FILL_W'(OUT_BYTES));

    // Merge the new word at the current byte offset
    always_comb begin
        asm_next = asm_data;
        asm_next[fill*8 +: $bits(in_word_t)] = port_data;
        for (int b = 0; b < OUT_BYTES; b++) begin
            keep_next[b] = (b < int'(fill_next));
        end
    end

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            pkt_open <= 1'b0;
            drop_pkt <= 1'b0;
        end else if (port_valid) begin
            pkt_open <= !port_last;
            if (!pkt_open) begin
                drop_pkt <= !port_enable;
            end
        end
    end

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            fill     <= '0;
            asm_data <= '0;
            wr_valid <= 1'b0;
            wr_entry <= '0;
            pkt_end  <= 1'b0;
        end else begin
            wr_valid <= take && complete;
            pkt_end  <= take && port_last;
            if (take) begin
                if (complete) begin
                    wr_entry.data <= asm_next;
                    wr_entry.keep <= keep_next;
                    wr_entry.last <= port_last;
                    fill          <= '0;
                    asm_data      <= '0;
                end else begin
                    fill     <= fill_next;
                    asm_data <= asm_next;
                end
            end
        end
    end

    // Framing and enable must be known on every word from the line
    a_ctrl_known: assert property (@(posedge clk_ifc) disable iff (!arst_n)
        port_valid |-> !$isunknown({port_last, port_enable}));

endmodule

// File: hdl/packet_fifo.sv
//////////////////////////////////////////////////
// Store-and-forward packet FIFO with drop on full
//////////////////////////////////////////////////
`timescale 1ns/1ps

module packet_fifo import ingress_pkg::*; (
    input  logic        clk_ifc,
    input  logic        arst_n,
    input  logic        wr_valid,
    input  fifo_entry_t wr_entry,
    input  logic        pkt_end,
    input  logic        pop,
    output fifo_entry_t head,
    output logic        pkt_avail,
    output logic        accepted,
    output logic        dropped,
    output logic        overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    fifo_entry_t mem [FIFO_DEPTH];

    fifo_ptr_t rd_ptr;
    // Tentative write pointer and the last committed packet boundary
    fifo_ptr_t wr_ptr;
    fifo_ptr_t cm_ptr;
    // Number of whole packets ready for the arbiter
    fifo_ptr_t pkt_cnt;
    logic      dropping;
    logic      full;
    logic      store;
    logic      commit;
    logic      pop_last;

    assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign store     = wr_valid && !dropping && !full;
    assign commit    = store && pkt_end;
    assign pop_last  = pop && head.last;
    assign head      = mem[rd_ptr[AW-1:0]];
    assign pkt_avail = (pkt_cnt != '0);

    always_ff @(posedge clk_ifc) begin
        if (store) begin
            mem[wr_ptr[AW-1:0]] <= wr_entry;
        end
    end

    //////////////////////////////////////////////////
    // Pointers, packet count and status

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            cm_ptr   <= '0;
            pkt_cnt  <= '0;
            dropping <= 1'b0;
            accepted <= 1'b0;
            dropped  <= 1'b0;
            overflow <= 1'b0;
        end else begin
            accepted <= commit;
            dropped  <= 1'b0;
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            pkt_cnt <= pkt_cnt + fifo_ptr_t'(commit) - fifo_ptr_t'(pop_last);
            if (wr_valid) begin
                if (dropping || full) begin
                    // Throw away the partial packet
                    wr_ptr   <= cm_ptr;
                    dropping <= !pkt_end;
                    if (pkt_end) begin
                        dropped  <= 1'b1;
                        overflow <= 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (pkt_end) begin
                        cm_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

    // The arbiter only reads packets that are complete here
    a_pop_committed: assert property (@(posedge clk_ifc) disable iff (!arst_n)
        pop |-> pkt_avail);

endmodule

// File: hdl/ingress_counters.sv
//////////////////////////////////////////////////
// Accepted and dropped packet counters of one port
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ingress_counters import ingress_pkg::*; (
    input  logic clk_ifc,
    input  logic arst_n,
    input  logic accepted,
    input  logic dropped,
    input  logic cnt_clear,
    output cnt_t pkt_cnt,
    output cnt_t drop_cnt
);

    // Both counters stick at all ones
    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            pkt_cnt  <= '0;
            drop_cnt <= '0;
        end else if (cnt_clear) begin
            pkt_cnt  <= '0;
            drop_cnt <= '0;
        end else begin
            if (accepted && (pkt_cnt != '1)) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
            if (dropped && (drop_cnt != '1)) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/ingress_arbiter.sv
//////////////////////////////////////////////////
// Round-robin packet arbiter onto the output stream
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ingress_arbiter import ingress_pkg::*; (
    input  logic        clk_ifc,
    input  logic        arst_n,
    input  logic        pkt_avail [NUM_PORTS],
    input  fifo_entry_t head [NUM_PORTS],
    input  logic        out_ready,
    output logic        pop [NUM_PORTS],
    output logic        out_valid,
    output out_data_t   out_data,
    output out_keep_t   out_keep,
    output logic        out_last,
    output port_idx_t   out_user
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t               state;
    port_idx_t            grant;
    port_idx_t            rr_ptr;
    port_idx_t            sel;
    logic                 found;
    logic                 xfer;
    logic [NUM_PORTS-1:0] pop_vec;

    // First port with a whole packet at or after rr_ptr
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = rr_ptr;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_PORTS;
            if (!found && pkt_avail[idx]) begin
                found = 1'b1;
                sel   = port_idx_t'(idx);
            end
        end
    end

    assign out_valid = (state == ST_BUSY);
    assign out_data  = head[grant].data;
    assign out_keep  = head[grant].keep;
    assign out_last  = head[grant].last;
    assign out_user  = grant;
    assign xfer      = out_valid && out_ready;

    always_comb begin
        pop_vec = '0;
        if (xfer) begin
            pop_vec[grant] = 1'b1;
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            pop[i] = pop_vec[i];
        end
    end

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_IDLE;
            grant  <= '0;
            rr_ptr <= '0;
        end else if (state == ST_IDLE) begin
            if (found) begin
                state <= ST_BUSY;
                grant <= sel;
            end
        end else if (xfer && out_last) begin
            // Next search starts after the port just served
            state  <= ST_IDLE;
            rr_ptr <= (grant == port_idx_t'(NUM_PORTS - 1)) ? '0 : grant + 1'b1;
        end
    end

    // The granted FIFO keeps its packet committed until the last word leaves
    a_grant_avail: assert property (@(posedge clk_ifc) disable iff (!arst_n)
        out_valid |-> pkt_avail[grant]);

    // Head of the granted FIFO must not move until it is taken
    a_out_stable: assert property (@(posedge clk_ifc) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
            && $stable(out_last) && $stable(out_user));

endmodule

// File: hdl/router_ingress.sv
//////////////////////////////////////////////////
// Router ingress top with per-port buffering
//////////////////////////////////////////////////
`timescale 1ns/1ps

module router_ingress import ingress_pkg::*; (
    input  logic      clk_ifc,
    input  logic      arst_n,
    input  logic      port_valid [NUM_PORTS],
    input  logic      port_last [NUM_PORTS],
    input  word8_t    narrow_data [NUM_8B_PORTS],
    input  word32_t   wide_data [NUM_32B_PORTS],
    input  logic      port_enable [NUM_PORTS],
    input  logic      cnt_clear [NUM_PORTS],
    input  logic      out_ready,
    output logic      out_valid,
    output out_data_t out_data,
    output out_keep_t out_keep,
    output logic      out_last,
    output port_idx_t out_user,
    output cnt_t      pkt_cnt [NUM_PORTS],
    output cnt_t      drop_cnt [NUM_PORTS],
    output logic      buf_overflow [NUM_PORTS]
);

    logic        wr_valid [NUM_PORTS];
    fifo_entry_t wr_entry [NUM_PORTS];
    logic        pkt_end [NUM_PORTS];
    fifo_entry_t head [NUM_PORTS];
    logic        pkt_avail [NUM_PORTS];
    logic        pop [NUM_PORTS];
    logic        accepted [NUM_PORTS];
    logic        dropped [NUM_PORTS];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        // Low indices are the 8-bit ports
        if (i < NUM_8B_PORTS) begin : g_narrow
            port_widener #(.in_word_t(word8_t)) i_widener (
                .clk_ifc(clk_ifc), .arst_n(arst_n),
                .port_valid(port_valid[i]), .port_data(narrow_data[i]),
                .port_last(port_last[i]), .port_enable(port_enable[i]),
                .wr_valid(wr_valid[i]), .wr_entry(wr_entry[i]), .pkt_end(pkt_end[i])
            );
        end else begin : g_wide
            port_widener #(.in_word_t(word32_t)) i_widener (
                .clk_ifc(clk_ifc), .arst_n(arst_n),
                .port_valid(port_valid[i]), .port_data(wide_data[i-NUM_8B_PORTS]),
                .port_last(port_last[i]), .port_enable(port_enable[i]),
                .wr_valid(wr_valid[i]), .wr_entry(wr_entry[i]), .pkt_end(pkt_end[i])
            );
        end

        packet_fifo i_fifo (
            .clk_ifc(clk_ifc), .arst_n(arst_n),
            .wr_valid(wr_valid[i]), .wr_entry(wr_entry[i]), .pkt_end(pkt_end[i]),
            .pop(pop[i]), .head(head[i]), .pkt_avail(pkt_avail[i]),
            .accepted(accepted[i]), .dropped(dropped[i]), .overflow(buf_overflow[i])
        );

        ingress_counters i_counters (
            .clk_ifc(clk_ifc), .arst_n(arst_n),
            .accepted(accepted[i]), .dropped(dropped[i]), .cnt_clear(cnt_clear[i]),
            .pkt_cnt(pkt_cnt[i]), .drop_cnt(drop_cnt[i])
        );
    end

    ingress_arbiter i_arbiter (
        .clk_ifc(clk_ifc), .arst_n(arst_n),
        .pkt_avail(pkt_avail), .head(head), .out_ready(out_ready), .pop(pop),
        .out_valid(out_valid), .out_data(out_data), .out_keep(out_keep),
        .out_last(out_last), .out_user(out_user)
    );

endmodule

// File: bench/router_ingress_tb.sv
//////////////////////////////////////////////////
// Testbench for the router ingress stage, driven
// from a command pattern file
//////////////////////////////////////////////////
`timescale 1ns/1ps

module router_ingress_tb import ingress_pkg::*; ();

    logic      clk_ifc;
    logic      arst_n;
    logic      port_valid [NUM_PORTS];
    logic      port_last [NUM_PORTS];
    word8_t    narrow_data [NUM_8B_PORTS];
    word32_t   wide_data [NUM_32B_PORTS];
    logic      port_enable [NUM_PORTS];
    logic      cnt_clear [NUM_PORTS];
    logic      out_ready;
    logic      out_valid;
    out_data_t out_data;
    out_keep_t out_keep;
    logic      out_last;
    port_idx_t out_user;
    cnt_t      pkt_cnt [NUM_PORTS];
    cnt_t      drop_cnt [NUM_PORTS];
    logic      buf_overflow [NUM_PORTS];

    // Parsed commands and their arguments
    string       cmd_q [$];
    int          arg_q [$][4];
    // Expected packets per port, as length and first byte
    int          exp_len [NUM_PORTS][$];
    int          exp_first [NUM_PORTS][$];
    // FIFO entries the model believes are held per port
    int          occ [NUM_PORTS];
    int          hold_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    logic [31:0] rng;

    // Output monitor state
    logic        in_pkt;
    port_idx_t   cur_port;
    int          cur_len;
    int          cur_first;
    int          byte_idx;
    logic        held;
    out_data_t   held_data;
    out_keep_t   held_keep;
    logic        held_last;
    port_idx_t   held_user;

    router_ingress i_router_ingress (.*);

    always #20 clk_ifc = !clk_ifc;

    //////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    // One clock, then out_ready for the new cycle
    task automatic step();
        @(posedge clk_ifc);
        #2;
        if (hold_cnt > 0) begin
            out_ready = 1'b0;
            hold_cnt--;
        end else begin
            rng       = xorshift(rng);
            out_ready = (rng[1:0] != 2'b00);
        end
    endtask

    task automatic load_patterns(output int total_bytes);
        int    fd;
        int    a [4];
        string cmd;
        string rest;
        total_bytes = 0;
        fd = $fopen("bench/ingress_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the pattern file");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                a = '{0, 0, 0, 0};
                if (cmd.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else begin
                    case (cmd)
                        "packet": void'($fscanf(fd, "%d %d %h", a[0], a[1], a[2]));
                        "enable": void'($fscanf(fd, "%d %d", a[0], a[1]));
                        "expect": void'($fscanf(fd, "%d %d %d %d", a[0], a[1], a[2], a[3]));
                        default:  void'($fscanf(fd, "%d", a[0]));
                    endcase
                    if (cmd == "packet") begin
                        total_bytes += a[1];
                    end
                    cmd_q.push_back(cmd);
                    arg_q.push_back(a);
                end
            end
            $fclose(fd);
        end
    endtask

    // Byte k of a packet is first + k
    task automatic send_packet(input int p, input int len, input int first);
        int width;
        int nwords;
        int entries;
        width   = (p < NUM_8B_PORTS) ? 1 : 4;
        nwords  = len / width;
        entries = (len + OUT_BYTES - 1) / OUT_BYTES;
        // Disabled ports ignore the packet, a full FIFO drops it
        if (port_enable[p] && (occ[p] + entries <= FIFO_DEPTH)) begin
            exp_len[p].push_back(len);
            exp_first[p].push_back(first);
            occ[p] += entries;
        end
        for (int w = 0; w < nwords; w++) begin
            step();
            port_valid[p] = 1'b1;
            port_last[p]  = (w == nwords - 1);
            if (p < NUM_8B_PORTS) begin
                narrow_data[p] = 8'(first + w);
            end else begin
                for (int b = 0; b < 4; b++) begin
                    wide_data[p - NUM_8B_PORTS][b*8 +: 8] = 8'(first + w * 4 + b);
                end
            end
        end
        step();
        port_valid[p] = 1'b0;
        port_last[p]  = 1'b0;
    endtask

    function automatic int pending_packets();
        int n;
        n = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            n += exp_len[i].size();
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // Output checker, sampled mid-cycle

    always @(negedge clk_ifc) begin : output_monitor
        logic [63:0] exp_data;
        logic [63:0] mask;
        int          rem;
        int          nbytes;
        if (arst_n) begin
            if (held) begin
                compare_value("out_valid", out_valid, 1);
                compare_value("out_data", out_data, held_data);
                compare_value("out_keep", out_keep, held_keep);
                compare_value("out_last", out_last, held_last);
                compare_value("out_user", out_user, held_user);
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
            held_keep = out_keep;
            held_last = out_last;
            held_user = out_user;
            if (out_valid && out_ready) begin
                if (!in_pkt && exp_len[out_user].size() == 0) begin
                    abort_run($sformatf("unexpected packet from port %0d", out_user));
                end else begin
                    if (!in_pkt) begin
                        cur_port  = out_user;
                        cur_len   = exp_len[cur_port][0];
                        cur_first = exp_first[cur_port][0];
                        byte_idx  = 0;
                        in_pkt    = 1'b1;
                    end
                    rem      = cur_len - byte_idx;
                    nbytes   = (rem > OUT_BYTES) ? OUT_BYTES : rem;
                    exp_data = '0;
                    mask     = '0;
                    for (int b = 0; b < nbytes; b++) begin
                        exp_data[b*8 +: 8] = 8'(cur_first + byte_idx + b);
                        mask[b*8 +: 8]     = 8'hff;
                    end
                    compare_value("out_user", out_user, cur_port);
                    compare_value("out_keep", out_keep, (64'd1 << nbytes) - 64'd1);
                    compare_value("out_last", out_last, 64'(rem <= OUT_BYTES));
                    compare_value("out_data", out_data & mask, exp_data);
                    byte_idx += nbytes;
                    occ[cur_port]--;
                    if (rem <= OUT_BYTES) begin
                        void'(exp_len[cur_port].pop_front());
                        void'(exp_first[cur_port].pop_front());
                        in_pkt = 1'b0;
                    end
                end
            end
        end
    end

    always @(posedge clk_ifc) begin : watchdog
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("run timed out after %0d cycles", cycle_cnt));
        end
    end

    //////////////////////////////////////////////////
    // Main flow

    initial begin : main_flow
        int    total_bytes;
        int    a [4];
        clk_ifc     = 1'b0;
        arst_n      = 1'b0;
        out_ready   = 1'b0;
        hold_cnt    = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        rng         = 32'hcabc;
        in_pkt      = 1'b0;
        held        = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            port_valid[i]  = 1'b0;
            port_last[i]   = 1'b0;
            port_enable[i] = 1'b1;
            cnt_clear[i]   = 1'b0;
            occ[i]         = 0;
        end
        for (int i = 0; i < NUM_8B_PORTS; i++) begin
            narrow_data[i] = '0;
        end
        for (int i = 0; i < NUM_32B_PORTS; i++) begin
            wide_data[i] = '0;
        end
        load_patterns(total_bytes);
        cycle_limit = 4 * total_bytes + 2000;
        repeat (3) step();
        arst_n = 1'b1;
        step();
        for (int i = 0; i < cmd_q.size(); i++) begin
            a = arg_q[i];
            case (cmd_q[i])
                "packet": send_packet(a[0], a[1], a[2]);
                "enable": port_enable[a[0]] = a[1][0];
                "hold":   hold_cnt = a[0];
                "wait":   repeat (a[0]) step();
                "clear": begin
                    cnt_clear[a[0]] = 1'b1;
                    step();
                    cnt_clear[a[0]] = 1'b0;
                end
                "expect": begin
                    compare_value($sformatf("pkt_cnt[%0d]", a[0]), pkt_cnt[a[0]], a[1]);
                    compare_value($sformatf("drop_cnt[%0d]", a[0]), drop_cnt[a[0]], a[2]);
                    compare_value($sformatf("buf_overflow[%0d]", a[0]),
                                  buf_overflow[a[0]], a[3]);
                end
                default: abort_run($sformatf("unknown command %s", cmd_q[i]));
            endcase
        end
        // Let every expected packet come out
        while (pending_packets() > 0) begin
            step();
        end
        repeat (10) step();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: bench/ingress_patterns.txt
# Commands: packet port len first_hex | enable port val | hold cycles | wait cycles
# clear port | expect port pkt_cnt drop_cnt overflow
# Mixed lengths on all four ports
packet 0 8 00
packet 1 13 40
packet 2 16 80
packet 3 20 c0
packet 0 1 10
packet 3 4 f0
packet 2 64 20
packet 1 64 01
wait 40
expect 0 2 0 0
expect 1 2 0 0
expect 2 2 0 0
expect 3 2 0 0
# Port 1 disabled for one packet
enable 1 0
packet 1 12 aa
packet 0 24 55
enable 1 1
packet 1 7 33
wait 20
expect 1 3 0 0
expect 0 3 0 0
wait 150
# Three full packets into port 2 while the output is stalled
hold 80
packet 2 64 00
packet 2 64 40
packet 2 64 80
wait 300
expect 2 4 1 1
expect 0 3 0 0
expect 1 3 0 0
expect 3 2 0 0
clear 0
clear 2
wait 2
expect 0 0 0 0
expect 2 0 0 1
expect 1 3 0 0
expect 3 2 0 0
packet 2 8 11
packet 0 3 22
wait 20
expect 2 1 0 1
expect 0 1 0 0

// File: flist.f
hdl/ingress_pkg.sv
hdl/port_widener.sv
hdl/packet_fifo.sv
hdl/ingress_counters.sv
hdl/ingress_arbiter.sv
hdl/router_ingress.sv
bench/router_ingress_tb.sv
